// File: list.f
verilog/vcache_prof_pkg.sv
verilog/op_classifier.sv
verilog/fill_classifier.sv
verilog/event_counters.sv
verilog/snapshot_streamer.sv
verilog/vcache_profiler.sv
sim/tb_clock.sv
sim/vcache_profiler_asserts.sv
sim/vcache_profiler_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module vcache_profiler_tb -f list.f -o vcache_profiler_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/vcache_profiler_sim > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Verification passed" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation passed"

// File: sim/vcache_profiler_tb.sv
// Testbench for the cache profiler. Reference counts follow the event rules
// of the cache side and are frozen on every accepted print request.
// The receiver pays back each record with one credit 0 to 3 cycles later.

`default_nettype none

module vcache_profiler_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import vcache_prof_pkg::*;

  localparam int max_cycles_lp = 20000; // about four times the five phases

  logic clk, reset;
  logic resp_v, resp_yumi, sigext, miss_v;
  logic dma_v, dma_yumi, dma_write, fill_cmd, dma_done;
  logic print_v, print_busy, stat_v, credit;
  cache_op_e                 op;
  amo_subop_e                amo_subop;
  event_id_e                 stat_id;
  logic [1:0]                size;
  logic [mask_width_lp-1:0]  mask;
  logic [way_width_lp-1:0]   chosen_way;
  logic [ways_lp-1:0]        valid, dirty;
  logic [count_width_lp-1:0] print_tag, stat_count, stat_tag;

  logic [num_events_lp-1:0]                     exp_ev;
  logic [num_events_lp-1:0][count_width_lp-1:0] ref_q;  // running reference
  logic [num_events_lp-1:0][count_width_lp-1:0] snap_q; // frozen at print
  logic [num_events_lp-1:0][count_width_lp-1:0] rx_q;   // records received
  logic [count_width_lp-1:0] tag_q, exp_count, ld_sub_sum, sm_sub_sum;
  logic        sums_on = 1'b0;
  logic [31:0] lfsr_q = 32'h6f9cf45b;
  int          cyc_q = 0;
  int          credit_due[$]; // cycle at which each owed credit goes back
  string       test_name = "reset_clear";

  tb_clock tb_clock_inst (.clk_o(clk), .reset_o(reset));

  vcache_profiler vcache_profiler_inst (
    .clk_i(clk), .reset_i(reset), .resp_v_i(resp_v), .resp_yumi_i(resp_yumi),
    .op_i(op), .size_i(size), .sigext_i(sigext), .mask_i(mask), .amo_subop_i(amo_subop),
    .miss_v_i(miss_v), .dma_pkt_v_i(dma_v), .dma_pkt_yumi_i(dma_yumi),
    .dma_write_i(dma_write), .fill_cmd_i(fill_cmd), .dma_done_i(dma_done),
    .chosen_way_i(chosen_way), .valid_i(valid), .dirty_i(dirty),
    .print_v_i(print_v), .print_tag_i(print_tag), .print_busy_o(print_busy),
    .stat_v_o(stat_v), .stat_id_o(stat_id), .stat_count_o(stat_count),
    .stat_tag_o(stat_tag), .credit_i(credit)
  );

  bind vcache_profiler vcache_profiler_asserts asserts_inst (
    .clk_i(clk_i), .reset_i(reset_i), .print_v_i(print_v_i), .print_busy_i(print_busy_o),
    .stat_v_i(stat_v_o), .stat_id_i(stat_id_o), .stat_tag_i(stat_tag_o), .credit_i(credit_i)
  );

  // Galois LFSR over x^32 + x^22 + x^2 + x + 1 with one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i]   = lfsr_q[0];
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[FAIL] %s: %s expected 0x%08h actual 0x%08h", test_name, what, expected, actual);
    $display("Verification failed");
    $fatal(1, "stat stream does not match the reference counts");
  endtask

  // one clock edge including the receiver side
  task automatic step_cycle();
    int pick;
    @(posedge clk);
    if (stat_v) begin
      credit_due.push_back(cyc_q + int'(rand_bits(2)));
    end
    pick = -1;
    for (int k = 0; k < credit_due.size(); k++) begin
      if (pick < 0 && credit_due[k] <= cyc_q) begin
        pick = k;
      end
    end
    if (pick >= 0) begin
      credit_due.delete(pick);
    end
    credit <= (pick >= 0); // at most one credit per cycle
  endtask

  task automatic drive_idle();
    resp_v <= 1'b0;
    resp_yumi <= 1'b0;
    op <= op_none;
    size <= 2'd0;
    sigext <= 1'b0;
    mask <= '0;
    amo_subop <= amo_swap;
    miss_v <= 1'b0;
    dma_v <= 1'b0;
    dma_yumi <= 1'b0;
    dma_write <= 1'b0;
    fill_cmd <= 1'b0;
    dma_done <= 1'b0;
    chosen_way <= '0;
    valid <= '0;
    dirty <= '0;
  endtask

  // restrict_kind keeps sizes at word or below and masks at 1, 2 or 4 bytes
  task automatic drive_request(input logic restrict_kind, input logic with_miss);
    logic [31:0] r;
    resp_v    <= 1'(rand_bits(1));
    resp_yumi <= 1'(rand_bits(1));
    op        <= cache_op_e'(3'(rand_bits(3) % 32'd5));
    sigext    <= 1'(rand_bits(1));
    amo_subop <= amo_subop_e'(2'(rand_bits(2)));
    miss_v    <= with_miss ? 1'(rand_bits(1)) : 1'b0;
    if (restrict_kind) begin
      size <= 2'(rand_bits(2) % 32'd3);
      r = rand_bits(2);
      case (r[1:0])
        2'd0:    mask <= 4'b0001 << 2'(rand_bits(2));
        2'd1:    mask <= (rand_bits(1) != 0) ? 4'b1100 : 4'b0011;
        default: mask <= 4'b1111;
      endcase
    end else begin
      size <= 2'(rand_bits(2));
      mask <= 4'(rand_bits(4));
    end
  endtask

  task automatic drive_fill();
    dma_v      <= 1'(rand_bits(1));
    dma_yumi   <= 1'(rand_bits(1));
    dma_write  <= 1'(rand_bits(1));
    fill_cmd   <= 1'(rand_bits(1));
    dma_done   <= 1'(rand_bits(1));
    chosen_way <= 3'(rand_bits(3));
    valid      <= 8'(rand_bits(8));
    dirty      <= 8'(rand_bits(8));
  endtask

  task automatic finish_stream(input logic traffic);
    while (print_busy) begin
      if (traffic) begin
        drive_request(1'b0, 1'b1);
      end
      step_cycle();
    end
  endtask

  task automatic run_print(input logic [31:0] tag);
    drive_idle();
    print_v   <= 1'b1;
    print_tag <= tag;
    step_cycle();
    print_v <= 1'b0;
    step_cycle();
    finish_stream(1'b0);
  endtask

  // events expected from the inputs of the current cycle
  always_comb begin
    int pop;
    logic fill;
    pop = 0;
    for (int i = 0; i < mask_width_lp; i++) begin
      pop += int'(mask[i]);
    end
    fill = fill_cmd & dma_done;
    exp_ev = '0;
    if (resp_v && resp_yumi) begin
      case (op)
        op_ld: begin
          exp_ev[ev_ld]      = 1'b1;
          exp_ev[ev_miss_ld] = miss_v;
          case (size)
            2'd0:    exp_ev[sigext ? ev_ld_lb : ev_ld_lbu] = 1'b1;
            2'd1:    exp_ev[sigext ? ev_ld_lh : ev_ld_lhu] = 1'b1;
            2'd2:    exp_ev[sigext ? ev_ld_lw : ev_ld_lwu] = 1'b1;
            default: ;
          endcase
        end
        op_st: begin
          exp_ev[ev_st]      = 1'b1;
          exp_ev[ev_miss_st] = miss_v;
          exp_ev[ev_sm_sw]   = (pop == 4);
          exp_ev[ev_sm_sh]   = (pop == 2);
          exp_ev[ev_sm_sb]   = (pop == 1);
        end
        op_maint: exp_ev[ev_maint] = 1'b1;
        op_amo: begin
          exp_ev[ev_atomic]   = 1'b1;
          exp_ev[ev_miss_amo] = miss_v;
          exp_ev[ev_amoswap]  = (amo_subop == amo_swap);
          exp_ev[ev_amoor]    = (amo_subop == amo_or);
          exp_ev[ev_amoadd]   = (amo_subop == amo_add);
        end
        default: ;
      endcase
    end
    exp_ev[ev_stall_miss] = miss_v;
    exp_ev[ev_stall_idle] = !resp_v && !miss_v;
    exp_ev[ev_stall_rsp]  = resp_v && !resp_yumi;
    exp_ev[ev_dma_read]   = dma_v && dma_yumi && !dma_write;
    exp_ev[ev_dma_write]  = dma_v && dma_yumi && dma_write;
    if (fill) begin
      if (!valid[chosen_way]) exp_ev[ev_replace_invalid] = 1'b1;
      else if (dirty[chosen_way]) exp_ev[ev_replace_dirty] = 1'b1;
      else exp_ev[ev_replace_valid] = 1'b1;
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      ref_q  <= '0;
      snap_q <= '0;
      tag_q  <= '0;
    end else begin
      for (int i = 0; i < num_events_lp; i++) begin
        ref_q[i] <= ref_q[i] + count_width_lp'(exp_ev[i]);
      end
      if (print_v && !print_busy) begin
        snap_q <= ref_q; // counts before the request cycle
        tag_q  <= print_tag;
      end
      if (stat_v) begin
        rx_q[stat_id] <= stat_count;
      end
    end
  end

  assign exp_count  = snap_q[stat_id];
  assign ld_sub_sum = rx_q[ev_ld_lw] + rx_q[ev_ld_lwu] + rx_q[ev_ld_lh]
                    + rx_q[ev_ld_lhu] + rx_q[ev_ld_lb] + rx_q[ev_ld_lbu];
  assign sm_sub_sum = rx_q[ev_sm_sw] + rx_q[ev_sm_sh] + rx_q[ev_sm_sb];

  count_check: assert property (@(posedge clk) disable iff (reset)
      stat_v |-> stat_count == exp_count)
    else report_mismatch($sformatf("count of event %0d", $sampled(stat_id)),
                         $sampled(exp_count), $sampled(stat_count));

  tag_check: assert property (@(posedge clk) disable iff (reset)
      stat_v |-> stat_tag == tag_q)
    else report_mismatch("snapshot tag", $sampled(tag_q), $sampled(stat_tag));

  ld_sum_check: assert property (@(posedge clk) disable iff (reset)
      $fell(print_busy) && sums_on |-> ld_sub_sum == rx_q[ev_ld])
    else report_mismatch("load sub-count sum", $sampled(rx_q[ev_ld]), $sampled(ld_sub_sum));

  st_sum_check: assert property (@(posedge clk) disable iff (reset)
      $fell(print_busy) && sums_on |-> sm_sub_sum == rx_q[ev_st])
    else report_mismatch("store sub-count sum", $sampled(rx_q[ev_st]), $sampled(sm_sub_sum));

  // failures counted by the bound protocol checker
  always @(posedge clk) begin
    if (vcache_profiler_inst.asserts_inst.errors_q != 0) begin
      $display("Stat stream protocol check failed during %s", test_name);
      $display("Verification failed");
      $fatal(1, "stat stream protocol violated");
    end
  end

  always @(posedge clk) begin
    cyc_q <= cyc_q + 1;
    if (cyc_q >= max_cycles_lp) begin
      $display("Timeout: the run went past %0d cycles without finishing", max_cycles_lp);
      $display("Verification failed");
      $fatal(1, "simulation timed out");
    end
  end

  initial begin
    print_v   = 1'b1; // held through reset and taken in the first free cycle
    print_tag = 32'h0000_0001;
    credit    = 1'b0;
    drive_idle();
    while (reset) begin
      step_cycle();
    end
    print_v <= 1'b0;
    step_cycle();
    finish_stream(1'b0);

    test_name = "op_classify";
    sums_on   = 1'b1;
    repeat (800) begin
      drive_request(1'b1, 1'b0);
      step_cycle();
    end
    run_print(32'h0000_0002);
    step_cycle();
    sums_on = 1'b0;
    repeat (700) begin
      drive_request(1'b0, 1'b0);
      step_cycle();
    end
    run_print(32'h0000_0003);

    test_name = "miss_stall";
    repeat (1200) begin
      drive_request(1'b0, 1'b1);
      step_cycle();
    end
    run_print(32'h0000_0004);

    test_name = "dma_replace";
    repeat (1200) begin
      drive_fill();
      step_cycle();
    end
    run_print(32'h0000_0005);

    test_name = "credit_stream";
    repeat (200) begin
      drive_request(1'b0, 1'b1);
      drive_fill();
      step_cycle();
    end
    print_v   <= 1'b1;
    print_tag <= 32'h0000_0006;
    step_cycle();
    print_v <= 1'b0;
    repeat (5) begin
      drive_request(1'b0, 1'b1);
      step_cycle();
    end
    print_v   <= 1'b1; // dropped since the stream is already running
    print_tag <= 32'hdead_0006;
    step_cycle();
    print_v <= 1'b0;
    finish_stream(1'b1);
    run_print(32'h0000_0007);

    drive_idle();
    repeat (4) step_cycle();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/vcache_profiler_asserts.sv
// Protocol checks on the stat stream and the print control of the profiler.
// Assumes the receiver returns exactly one credit per record, never more.

`default_nettype none

module vcache_profiler_asserts (
  input logic                                       clk_i,
  input logic                                       reset_i,
  input logic                                       print_v_i,
  input logic                                       print_busy_i,
  input logic                                       stat_v_i,
  input vcache_prof_pkg::event_id_e                 stat_id_i,
  input logic [vcache_prof_pkg::count_width_lp-1:0] stat_tag_i,
  input logic                                       credit_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import vcache_prof_pkg::*;

  int outstanding_q;  // records sent and not yet paid back
  int next_id_q;      // id the next record has to carry
  int errors_q = 0;   // failed assertions so far

  always @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_q <= 0;
      next_id_q     <= 0;
    end else begin
      outstanding_q <= outstanding_q + int'(stat_v_i) - int'(credit_i);
      if (stat_v_i) begin
        next_id_q <= (int'(stat_id_i) == num_events_lp - 1) ? 0 : int'(stat_id_i) + 1;
      end
    end
  end

  no_send_without_credit: assert property (@(posedge clk_i) disable iff (reset_i)
      outstanding_q >= num_credits_lp |-> !stat_v_i)
    else begin
      $error("record sent while the receiver had no credit left");
      errors_q = errors_q + 1;
    end

  records_in_order: assert property (@(posedge clk_i) disable iff (reset_i)
      stat_v_i |-> int'(stat_id_i) == next_id_q)
    else begin
      $error("stat record id out of order");
      errors_q = errors_q + 1;
    end

  idle_after_reset: assert property (@(posedge clk_i)
      reset_i |=> !print_busy_i && !stat_v_i)
    else begin
      $error("stream not idle after reset");
      errors_q = errors_q + 1;
    end

  idle_after_last: assert property (@(posedge clk_i) disable iff (reset_i)
      stat_v_i && stat_id_i == ev_replace_dirty |=> !print_busy_i)
    else begin
      $error("print_busy_o still high after the last record");
      errors_q = errors_q + 1;
    end

  // a dropped request must leave the running snapshot alone
  busy_print_ignored: assert property (@(posedge clk_i) disable iff (reset_i)
      print_v_i && print_busy_i |=> $stable(stat_tag_i))
    else begin
      $error("print request while busy changed the running snapshot");
      errors_q = errors_q + 1;
    end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
// Free-running 100 ns clock for the testbench.
// Reset is high from time zero and drops after the eighth rising edge.

`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o; // 100 ns period
  end

  initial begin
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

// File: verilog/vcache_profiler.sv
// Event profiler for a non-blocking data cache, observing only.
// All inputs are sampled from the cache's own signals in the same cycle.
// Counts leave the block only through the credit-paced stat stream.

`default_nettype none

module vcache_profiler (
  input  logic                                       clk_i,
  input  logic                                       reset_i,

  // response and decoded request
  input  logic                                       resp_v_i,
  input  logic                                       resp_yumi_i,
  input  vcache_prof_pkg::cache_op_e                 op_i,
  input  logic [1:0]                                 size_i,
  input  logic                                       sigext_i,
  input  logic [vcache_prof_pkg::mask_width_lp-1:0]  mask_i,
  input  vcache_prof_pkg::amo_subop_e                amo_subop_i,

  // miss handler, DMA and fill state
  input  logic                                       miss_v_i,
  input  logic                                       dma_pkt_v_i,
  input  logic                                       dma_pkt_yumi_i,
  input  logic                                       dma_write_i,
  input  logic                                       fill_cmd_i,
  input  logic                                       dma_done_i,
  input  logic [vcache_prof_pkg::way_width_lp-1:0]   chosen_way_i,
  input  logic [vcache_prof_pkg::ways_lp-1:0]        valid_i,
  input  logic [vcache_prof_pkg::ways_lp-1:0]        dirty_i,

  input  logic                                       print_v_i,
  input  logic [vcache_prof_pkg::count_width_lp-1:0] print_tag_i,
  output logic                                       print_busy_o,

  output logic                                       stat_v_o,
  output vcache_prof_pkg::event_id_e                 stat_id_o,
  output logic [vcache_prof_pkg::count_width_lp-1:0] stat_count_o,
  output logic [vcache_prof_pkg::count_width_lp-1:0] stat_tag_o,
  input  logic                                       credit_i
);
  import vcache_prof_pkg::*;

  logic [ev_miss_amo:0]                         req_events;
  logic [ev_replace_dirty:ev_stall_miss]        cycle_events;
  logic [num_events_lp-1:0]                     events;
  logic [num_events_lp-1:0][count_width_lp-1:0] counts;

  assign events = {cycle_events, req_events}; // ids 0..18 low, 19..26 high

  op_classifier op_classifier_inst (
    .resp_v_i     (resp_v_i),
    .resp_yumi_i  (resp_yumi_i),
    .miss_v_i     (miss_v_i),
    .sigext_i     (sigext_i),
    .op_i         (op_i),
    .size_i       (size_i),
    .mask_i       (mask_i),
    .amo_subop_i  (amo_subop_i),
    .req_events_o (req_events)
  );

  fill_classifier fill_classifier_inst (
    .resp_v_i       (resp_v_i),
    .resp_yumi_i    (resp_yumi_i),
    .miss_v_i       (miss_v_i),
    .dma_pkt_v_i    (dma_pkt_v_i),
    .dma_pkt_yumi_i (dma_pkt_yumi_i),
    .dma_write_i    (dma_write_i),
    .fill_cmd_i     (fill_cmd_i),
    .dma_done_i     (dma_done_i),
    .chosen_way_i   (chosen_way_i),
    .valid_i        (valid_i),
    .dirty_i        (dirty_i),
    .cycle_events_o (cycle_events)
  );

  event_counters event_counters_inst (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .events_i (events),
    .counts_o (counts)
  );

  snapshot_streamer snapshot_streamer_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .print_v_i    (print_v_i),
    .credit_i     (credit_i),
    .print_tag_i  (print_tag_i),
    .counts_i     (counts),
    .print_busy_o (print_busy_o),
    .stat_v_o     (stat_v_o),
    .stat_id_o    (stat_id_o),
    .stat_count_o (stat_count_o),
    .stat_tag_o   (stat_tag_o)
  );

endmodule

`default_nettype wire

// File: verilog/snapshot_streamer.sv
// Freezes all event counters on a print request and streams one record per
// event, ids 0 to 26, at most one per cycle. The receiver returns one credit
// per record with a single-cycle credit_i pulse; num_credits_lp are assumed
// granted at reset. Print requests while print_busy_o is high are dropped.

`default_nettype none

module snapshot_streamer (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       print_v_i,
  input  logic                                       credit_i,
  input  logic [vcache_prof_pkg::count_width_lp-1:0] print_tag_i,
  input  logic [vcache_prof_pkg::num_events_lp-1:0][vcache_prof_pkg::count_width_lp-1:0]
               counts_i,
  output logic                                       print_busy_o,
  output logic                                       stat_v_o,
  output vcache_prof_pkg::event_id_e                 stat_id_o,
  output logic [vcache_prof_pkg::count_width_lp-1:0] stat_count_o,
  output logic [vcache_prof_pkg::count_width_lp-1:0] stat_tag_o
);
  import vcache_prof_pkg::*;

  logic [num_events_lp-1:0][count_width_lp-1:0] snap_r;
  logic [count_width_lp-1:0]                    tag_r;
  logic                                         busy_r;
  event_id_e                                    idx_r;   // record being offered
  logic [credit_width_lp-1:0]                   credits_r;

  logic print_accept;
  logic send;
  logic last_rec;

  assign print_accept = print_v_i & ~busy_r;
  assign send         = busy_r & (credits_r != '0);
  assign last_rec     = (idx_r == event_id_e'(num_events_lp - 1));

  // snapshot and walk through the records
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
      idx_r  <= ev_ld;
      snap_r <= '0;
      tag_r  <= '0;
    end else if (print_accept) begin
      busy_r <= 1'b1;
      idx_r  <= ev_ld;
      snap_r <= counts_i; // counts up to the cycle before the request
      tag_r  <= print_tag_i;
    end else if (send) begin
      if (last_rec) begin
        busy_r <= 1'b0;
        idx_r  <= ev_ld;
      end else begin
        idx_r <= event_id_e'(idx_r + 1'b1);
      end
    end
  end

  // credit counter, saturates at the initial grant
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_r <= credit_width_lp'(num_credits_lp);
    end else begin
      case ({send, credit_i})
        2'b10: credits_r <= credits_r - 1'b1;
        2'b01: begin
          if (credits_r != credit_width_lp'(num_credits_lp)) begin
            credits_r <= credits_r + 1'b1;
          end
        end
        default: credits_r <= credits_r; // idle, or send and return together
      endcase
    end
  end

  assign print_busy_o = busy_r;
  assign stat_v_o     = send;
  assign stat_id_o    = idx_r;
  assign stat_count_o = snap_r[idx_r];
  assign stat_tag_o   = tag_r;

endmodule

`default_nettype wire

// File: verilog/event_counters.sv
// One free-running counter per profiler event.
// An event seen in a cycle shows up in its counter after the next rising edge.
// Counters wrap silently modulo 2^32; software must sample often enough.

`default_nettype none

module event_counters (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic [vcache_prof_pkg::num_events_lp-1:0]  events_i,
  output logic [vcache_prof_pkg::num_events_lp-1:0][vcache_prof_pkg::count_width_lp-1:0]
               counts_o
);
  import vcache_prof_pkg::*;

  logic [num_events_lp-1:0][count_width_lp-1:0] counts_r;
  logic [num_events_lp-1:0][count_width_lp-1:0] counts_n;

  // next value of every counter
  always_comb begin
    for (int i = 0; i < num_events_lp; i++) begin
      counts_n[i] = counts_r[i] + count_width_lp'(events_i[i]); // wraps at the top
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      counts_r <= '0;
    end else begin
      counts_r <= counts_n;
    end
  end

  assign counts_o = counts_r;

endmodule

`default_nettype wire

// File: verilog/fill_classifier.sv
// Cycle events from the miss handler, response port, DMA port and fill logic.
// Combinational. chosen_way_i, valid_i and dirty_i must describe the way being
// filled in the cycle where fill_cmd_i and dma_done_i are both high.

`default_nettype none

module fill_classifier (
  input  logic                                     resp_v_i,
  input  logic                                     resp_yumi_i,
  input  logic                                     miss_v_i,
  input  logic                                     dma_pkt_v_i,
  input  logic                                     dma_pkt_yumi_i,
  input  logic                                     dma_write_i,
  input  logic                                     fill_cmd_i,
  input  logic                                     dma_done_i,
  input  logic [vcache_prof_pkg::way_width_lp-1:0] chosen_way_i,
  input  logic [vcache_prof_pkg::ways_lp-1:0]      valid_i,
  input  logic [vcache_prof_pkg::ways_lp-1:0]      dirty_i,
  output logic [vcache_prof_pkg::ev_replace_dirty:vcache_prof_pkg::ev_stall_miss] cycle_events_o
);
  import vcache_prof_pkg::*;

  logic dma_taken;
  logic replacing;
  logic way_valid;
  logic way_dirty;

  assign dma_taken = dma_pkt_v_i & dma_pkt_yumi_i;
  assign replacing = fill_cmd_i & dma_done_i; // fill address sent and done
  assign way_valid = valid_i[chosen_way_i];
  assign way_dirty = dirty_i[chosen_way_i];

  always_comb begin
    cycle_events_o = '0;
    cycle_events_o[ev_stall_miss] = miss_v_i;
    cycle_events_o[ev_stall_idle] = ~resp_v_i & ~miss_v_i;
    cycle_events_o[ev_stall_rsp]  = resp_v_i & ~resp_yumi_i; // network backpressure

    cycle_events_o[ev_dma_read]  = dma_taken & ~dma_write_i;
    cycle_events_o[ev_dma_write] = dma_taken & dma_write_i;

    cycle_events_o[ev_replace_invalid] = replacing & ~way_valid;
    cycle_events_o[ev_replace_valid]   = replacing & way_valid & ~way_dirty;
    cycle_events_o[ev_replace_dirty]   = replacing & way_valid & way_dirty;
  end

endmodule

`default_nettype wire

// File: verilog/op_classifier.sv
// Classifies accepted cache responses into request events.
// Purely combinational; an event is raised in the cycle of resp_v_i & resp_yumi_i.
// Load sizes above word and store masks other than 1, 2 or 4 bytes only
// raise the plain ld or st event.

`default_nettype none

module op_classifier (
  input  logic                                    resp_v_i,
  input  logic                                    resp_yumi_i,
  input  logic                                    miss_v_i,
  input  logic                                    sigext_i,
  input  vcache_prof_pkg::cache_op_e              op_i,
  input  logic [1:0]                              size_i,
  input  logic [vcache_prof_pkg::mask_width_lp-1:0] mask_i,
  input  vcache_prof_pkg::amo_subop_e             amo_subop_i,
  output logic [vcache_prof_pkg::ev_miss_amo:0]   req_events_o
);
  import vcache_prof_pkg::*;

  logic       accepted;
  logic       is_ld;
  logic       is_st;
  logic       is_maint;
  logic       is_amo;
  logic       size_w;
  logic       size_h;
  logic       size_b;
  logic [2:0] mask_pop; // set bytes in the store mask

  assign accepted = resp_v_i & resp_yumi_i;

  assign is_ld    = accepted & (op_i == op_ld);
  assign is_st    = accepted & (op_i == op_st);
  assign is_maint = accepted & (op_i == op_maint);
  assign is_amo   = accepted & (op_i == op_amo);

  assign size_w = (size_i == 2'b10);
  assign size_h = (size_i == 2'b01);
  assign size_b = (size_i == 2'b00);

  assign mask_pop = 3'($countones(mask_i));

  always_comb begin
    req_events_o = '0;

    // loads, split by access size and sign extension
    req_events_o[ev_ld]     = is_ld;
    req_events_o[ev_ld_lw]  = is_ld & size_w & sigext_i;
    req_events_o[ev_ld_lwu] = is_ld & size_w & ~sigext_i;
    req_events_o[ev_ld_lh]  = is_ld & size_h & sigext_i;
    req_events_o[ev_ld_lhu] = is_ld & size_h & ~sigext_i;
    req_events_o[ev_ld_lb]  = is_ld & size_b & sigext_i;
    req_events_o[ev_ld_lbu] = is_ld & size_b & ~sigext_i;

    // every store goes through the masked path
    req_events_o[ev_st]    = is_st;
    req_events_o[ev_sm_sw] = is_st & (mask_pop == 3'd4);
    req_events_o[ev_sm_sh] = is_st & (mask_pop == 3'd2);
    req_events_o[ev_sm_sb] = is_st & (mask_pop == 3'd1);

    req_events_o[ev_maint] = is_maint; // all tag/addr ops share one counter

    req_events_o[ev_atomic]  = is_amo;
    req_events_o[ev_amoswap] = is_amo & (amo_subop_i == amo_swap);
    req_events_o[ev_amoor]   = is_amo & (amo_subop_i == amo_or);
    req_events_o[ev_amoadd]  = is_amo & (amo_subop_i == amo_add);

    // response that came back through the miss handler
    req_events_o[ev_miss_ld]  = is_ld & miss_v_i;
    req_events_o[ev_miss_st]  = is_st & miss_v_i;
    req_events_o[ev_miss_amo] = is_amo & miss_v_i;
  end

endmodule

`default_nettype wire

// File: verilog/vcache_prof_pkg.sv
// Shared widths, opcode encodings and event indices for the cache profiler.
// Only 32-bit data is profiled; 64-bit sizes and masks are not classified.
// Event indices double as the record order on the stat stream.

`default_nettype none

package vcache_prof_pkg;

  localparam int count_width_lp    = 32; // counters and snapshot tag
  localparam int ways_lp           = 8;
  localparam int way_width_lp      = 3;
  localparam int mask_width_lp     = 4;  // byte mask of a 32-bit word
  localparam int num_events_lp     = 27;
  localparam int event_id_width_lp = 5;
  localparam int num_credits_lp    = 4;  // granted by the receiver after reset
  localparam int credit_width_lp   = $clog2(num_credits_lp + 1);

  // decoded operation of the request being answered
  typedef enum logic [2:0] {
    op_none  = 3'd0,
    op_ld    = 3'd1,
    op_st    = 3'd2,
    op_maint = 3'd3, // tag and address maintenance ops
    op_amo   = 3'd4
  } cache_op_e;

  typedef enum logic [1:0] {
    amo_swap  = 2'd0,
    amo_or    = 2'd1,
    amo_add   = 2'd2,
    amo_other = 2'd3 // counted as atomic only
  } amo_subop_e;

  typedef enum logic [event_id_width_lp-1:0] {
    ev_ld              = 5'd0,
    ev_ld_lw           = 5'd1,
    ev_ld_lwu          = 5'd2,
    ev_ld_lh           = 5'd3,
    ev_ld_lhu          = 5'd4,
    ev_ld_lb           = 5'd5,
    ev_ld_lbu          = 5'd6,
    ev_st              = 5'd7,
    ev_sm_sw           = 5'd8,
    ev_sm_sh           = 5'd9,
    ev_sm_sb           = 5'd10,
    ev_maint           = 5'd11,
    ev_atomic          = 5'd12,
    ev_amoswap         = 5'd13,
    ev_amoor           = 5'd14,
    ev_amoadd          = 5'd15,
    ev_miss_ld         = 5'd16,
    ev_miss_st         = 5'd17,
    ev_miss_amo        = 5'd18, // last request event
    ev_stall_miss      = 5'd19, // first cycle event
    ev_stall_idle      = 5'd20,
    ev_stall_rsp       = 5'd21,
    ev_dma_read        = 5'd22,
    ev_dma_write       = 5'd23,
    ev_replace_invalid = 5'd24,
    ev_replace_valid   = 5'd25,
    ev_replace_dirty   = 5'd26
  } event_id_e;

endpackage

`default_nettype wire
